// ==== design/nocPkg.sv ====
`default_nettype none

package nocPkg;

  localparam int NUM_PORTS        = 5;
  localparam int QUEUE_DEPTH      = 4;  // also the credits each upstream sender starts with.
  localparam int DOWNSTREAM_DEPTH = 4;
  localparam int PAYLOAD_W        = 16;
  localparam int LEN_W            = 8;

  // derived widths for pointers and counters.
  localparam int QPTR_W   = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W   = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_W = $clog2(DOWNSTREAM_DEPTH + 1);

  // the declaration order is also the priority order of the arbiter.
  typedef enum logic [2:0] {
    PORT_L,
    PORT_N,
    PORT_E,
    PORT_W,
    PORT_S
  } portId_t;

  typedef enum logic [1:0] {
    FLIT_HEAD,
    FLIT_BODY,
    FLIT_TAIL
  } flitKind_t;

  // a head flit carries the packet length, head included, in payload[LEN_W-1:0].
  typedef struct packed {
    flitKind_t              kind;
    logic [PAYLOAD_W-1:0]   payload;
  } flit_t;

endpackage

`default_nettype wire

// ==== design/arbPkg.sv ====
`default_nettype none

package arbPkg;

  // one grant state per input port, in the same order as portId_t.
  typedef enum logic [2:0] {
    ARB_IDLE,
    GRANT_L,
    GRANT_N,
    GRANT_E,
    GRANT_W,
    GRANT_S
  } arbState_t;

  // grant handed from the arbiter to the output link and the packet tracker.
  typedef struct packed {
    logic             active;
    nocPkg::portId_t  port;
  } grant_t;

endpackage

`default_nettype wire

// ==== design/inputQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputQueue
  import nocPkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire flit_t inFlit,
  input  wire logic  inValid,
  input  wire logic  pop,
  output flit_t      frontFlit,
  output logic       notEmpty,
  output logic       creditReturn
);

  flit_t              mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0]  rdPtr;
  logic [QPTR_W-1:0]  wrPtr;
  logic [QCNT_W-1:0]  count;

  assign frontFlit = mem[rdPtr];
  assign notEmpty  = (count != '0);

  always_ff @(posedge clk)
  begin
    if (inValid)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr        <= '0;
      wrPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end
    else
    begin
      if (inValid)
        wrPtr <= (wrPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({inValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      creditReturn <= pop;  // the freed slot goes back to the sender next cycle.
    end
  end

  // the sender only writes with a credit in hand, so the queue never fills past depth.
  assert property (@(posedge clk) disable iff (rst)
    inValid |-> count != QCNT_W'(QUEUE_DEPTH))
    else $error("inputQueue: write while full.");

  // pops come from the output link and must only hit a queue holding a flit.
  assert property (@(posedge clk) disable iff (rst)
    pop |-> notEmpty)
    else $error("inputQueue: pop while empty.");

endmodule

`default_nettype wire

// ==== design/packetTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module packetTracker
  import nocPkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire flitKind_t        frontKind,
  input  wire logic [LEN_W-1:0] frontLength,
  input  wire logic             send,
  output logic                  packetDone
);

  logic [LEN_W-1:0] sentCount;
  logic [LEN_W-1:0] pktLen;
  logic [LEN_W-1:0] curLen;
  logic             isLast;

  // at a packet boundary the length comes straight from the head being sent.
  assign curLen     = (sentCount == '0) ? frontLength : pktLen;
  assign isLast     = (LEN_W'(sentCount + 1'b1) >= curLen);  // a length of 0 acts as 1.
  assign packetDone = send && isLast;

  always_ff @(posedge clk)
  begin
    if (send && sentCount == '0)
      pktLen <= frontLength;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sentCount <= '0;
    else if (send)
      sentCount <= isLast ? '0 : sentCount + 1'b1;
  end

  // queues and arbiter together must always present a head at a packet boundary.
  assert property (@(posedge clk) disable iff (rst)
    send && sentCount == '0 |-> frontKind == FLIT_HEAD)
    else $error("packetTracker: first flit of a packet is not a head.");

endmodule

`default_nettype wire

// ==== design/outputArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import nocPkg::*, arbPkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [NUM_PORTS-1:0] requests,
  input  wire logic                 packetDone,
  output grant_t                    grant
);

  arbState_t state;
  arbState_t nextState;

  // Searches the ports cyclically, starting with the one after served.
  // The served port itself is looked at last, and ARB_IDLE comes back if nobody asks.
  function automatic arbState_t pickNext(input int served, input logic [NUM_PORTS-1:0] req);
    arbState_t pick;
    int        idx;
    pick = ARB_IDLE;
    // walk from the farthest candidate to the nearest so the nearest wins.
    for (int k = NUM_PORTS; k >= 1; k--)
    begin
      idx = (served + k) % NUM_PORTS;
      if (req[idx])
        pick = arbState_t'(3'(idx + 1));
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      ARB_IDLE:
      begin
        // starting the search after S gives fixed priority with L first.
        nextState = pickNext(NUM_PORTS - 1, requests);
      end
      GRANT_L, GRANT_N, GRANT_E, GRANT_W, GRANT_S:
      begin
        if (packetDone)
          nextState = pickNext(int'(grant.port), requests);
      end
      default:
      begin
        nextState = ARB_IDLE;
      end
    endcase
  end

  // The grant is a plain decode of the state register.
  always_comb
  begin
    grant.active = (state != ARB_IDLE);
    grant.port   = PORT_L;
    case (state)
      GRANT_L: grant.port = PORT_L;
      GRANT_N: grant.port = PORT_N;
      GRANT_E: grant.port = PORT_E;
      GRANT_W: grant.port = PORT_W;
      GRANT_S: grant.port = PORT_S;
      default: grant.port = PORT_L;
    endcase
  end

  // nothing can be sent without a grant, so the tracker cannot end a packet here.
  assert property (@(posedge clk) disable iff (rst)
    state == ARB_IDLE |-> !packetDone)
    else $error("outputArbiter: packetDone while idle.");

endmodule

`default_nettype wire

// ==== design/outputLink.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputLink
  import nocPkg::*, arbPkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire grant_t               grant,
  input  wire flit_t                frontFlits [NUM_PORTS],
  input  wire logic [NUM_PORTS-1:0] frontValid,
  input  wire logic                 outCredit,
  output logic                      send,
  output flit_t                     selFlit,
  output logic [NUM_PORTS-1:0]      pops,
  output flit_t                     outFlit,
  output logic                      outValid
);

  logic [CREDIT_W-1:0] credits;

  assign selFlit = frontFlits[grant.port];
  assign send    = grant.active && frontValid[grant.port] && (credits != '0);
  assign pops    = send ? (NUM_PORTS'(1) << grant.port) : '0;

  always_ff @(posedge clk)
  begin
    if (send)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      credits  <= CREDIT_W'(DOWNSTREAM_DEPTH);
    end
    else
    begin
      outValid <= send;
      case ({send, outCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // a send and a returned credit cancel out.
      endcase
    end
  end

  // downstream may only return credits for slots this link has filled.
  assert property (@(posedge clk) disable iff (rst)
    credits <= CREDIT_W'(DOWNSTREAM_DEPTH))
    else $error("outputLink: credit count above downstream depth.");

endmodule

`default_nettype wire

// ==== design/routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import nocPkg::*, arbPkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire flit_t                inFlits [NUM_PORTS],
  input  wire logic [NUM_PORTS-1:0] inValids,
  output logic [NUM_PORTS-1:0]      creditReturns,
  output flit_t                     outFlit,
  output logic                      outValid,
  input  wire logic                 outCredit
);

  flit_t                frontFlits [NUM_PORTS];
  logic [NUM_PORTS-1:0] notEmpty;
  logic [NUM_PORTS-1:0] pops;
  logic [NUM_PORTS-1:0] requests;
  grant_t               grant;
  flit_t                selFlit;
  logic                 send;
  logic                 packetDone;

  // A queue being popped is left out of the request vector for that cycle.
  // Otherwise a queue whose last flit just left could be granted again and hold
  // the output while empty.
  assign requests = notEmpty & ~pops;

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gQueue
    inputQueue i_queue (
      .clk          (clk),
      .rst          (rst),
      .inFlit       (inFlits[p]),
      .inValid      (inValids[p]),
      .pop          (pops[p]),
      .frontFlit    (frontFlits[p]),
      .notEmpty     (notEmpty[p]),
      .creditReturn (creditReturns[p])
    );
  end

  outputArbiter i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .requests   (requests),
    .packetDone (packetDone),
    .grant      (grant)
  );

  packetTracker i_tracker (
    .clk         (clk),
    .rst         (rst),
    .frontKind   (selFlit.kind),
    .frontLength (selFlit.payload[LEN_W-1:0]),
    .send        (send),
    .packetDone  (packetDone)
  );

  outputLink i_link (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .frontFlits (frontFlits),
    .frontValid (notEmpty),
    .outCredit  (outCredit),
    .send       (send),
    .selFlit    (selFlit),
    .pops       (pops),
    .outFlit    (outFlit),
    .outValid   (outValid)
  );

endmodule

`default_nettype wire

// ==== tests/tbRouterOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort
  import nocPkg::*;
();

  logic                 clk = 1'b0;
  logic                 rst;
  flit_t                inFlits [NUM_PORTS];
  logic [NUM_PORTS-1:0] inValids;
  logic [NUM_PORTS-1:0] creditReturns;
  flit_t                outFlit;
  logic                 outValid;
  logic                 outCredit;

  // each upstream source keeps a pending flit list and a credit counter.
  flit_t pend [NUM_PORTS][$];
  int    pendPkts [NUM_PORTS];
  int    pktNum [NUM_PORTS];
  int    cred [NUM_PORTS];
  int    sent [NUM_PORTS];
  int    crCount [NUM_PORTS];
  int    drivenTotal = 0;
  int    totalFlits = 0;

  // scoreboard and downstream buffer model.
  int    expPkt [NUM_PORTS];
  int    curSrc, curPkt, remaining, nextIdx;
  int    received = 0;
  int    owed = 0;
  int    returned = 0;
  int    stallLeft = 0;
  int    stalls = 0;
  int    idleRun = 0;
  int    prevHead, rotHeads;
  logic  rotOn = 1'b0;
  logic  stallsOn = 1'b0;
  int    cycle = 0;
  int    firstDrive = -1;
  int    firstOut = -1;
  int    errors = 0;
  logic  rstQ = 1'b0;
  logic  rstQ2 = 1'b0;

  routerOutputPort i_dut (
    .clk           (clk),
    .rst           (rst),
    .inFlits       (inFlits),
    .inValids      (inValids),
    .creditReturns (creditReturns),
    .outFlit       (outFlit),
    .outValid      (outValid),
    .outCredit     (outCredit)
  );

  always #5 clk = ~clk;

  task automatic reportMismatch(input string msg);
    errors++;
    $display("Mismatch at %0d ns: %s", $time, msg);
  endtask

  task automatic noteFailure(input string msg);
    errors++;
    $display("Failure at %0d ns: %s", $time, msg);
  endtask

  function automatic int randomLen();
    return int'($urandom_range(1, 6));
  endfunction

  // payload is {source port, packet number, flit index} except in the head, which holds the length.
  task automatic queuePacket(input int port, input int len);
    flit_t f;
    for (int i = 0; i < len; i++)
    begin
      f.kind    = (i == 0) ? FLIT_HEAD : ((i == len - 1) ? FLIT_TAIL : FLIT_BODY);
      f.payload = {3'(port), 5'(pktNum[port]), (i == 0) ? 8'(len) : 8'(i)};
      pend[port].push_back(f);
    end
    pendPkts[port]++;
    pktNum[port] = (pktNum[port] + 1) % 32;
    totalFlits += len;
  endtask

  task automatic checkHead(input int src, input int pkt, input int len);
    assert (remaining == 0)
    else reportMismatch($sformatf("head from port %0d cut into a packet missing %0d flits",
                                  src, remaining));
    assert (src < NUM_PORTS && len >= 1 && len <= 6)
    else reportMismatch($sformatf("head with port %0d and length %0d", src, len));
    if (src < NUM_PORTS)
    begin
      assert (pkt == expPkt[src])
      else reportMismatch($sformatf("port %0d sent packet %0d, expected %0d",
                                    src, pkt, expPkt[src]));
      expPkt[src] = (pkt + 1) % 32;  // the next packet from this port follows the one just seen.
    end
    if (rotOn)
    begin
      if (prevHead >= 0)
        assert (src == (prevHead + 1) % NUM_PORTS)
        else reportMismatch($sformatf("head from port %0d followed port %0d", src, prevHead));
      prevHead = src;
      rotHeads++;
    end
    curSrc    = src;
    curPkt    = pkt;
    remaining = len - 1;
    nextIdx   = 1;
  endtask

  task automatic checkBody(input flitKind_t kind, input int src, input int pkt, input int idx);
    flitKind_t expKind;
    expKind = (remaining == 1) ? FLIT_TAIL : FLIT_BODY;
    assert (remaining > 0)
    else reportMismatch($sformatf("%s flit from port %0d outside any packet", kind.name(), src));
    assert (src == curSrc && pkt == curPkt && idx == nextIdx)
    else reportMismatch($sformatf("got port %0d packet %0d flit %0d, expected %0d/%0d/%0d",
                                  src, pkt, idx, curSrc, curPkt, nextIdx));
    assert (kind == expKind)
    else reportMismatch($sformatf("flit kind %s, expected %s", kind.name(), expKind.name()));
    if (remaining > 0)
      remaining--;
    nextIdx++;
  endtask

  task automatic waitDrain();
    while (received != totalFlits || owed != 0)
      @(negedge clk);
  endtask

  // sources spend a credit per flit and take back one per creditReturn pulse.
  always @(posedge clk)
  begin
    int avail;
    int nDriven;
    nDriven = 0;
    if (!rst)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        avail = cred[p] + int'(creditReturns[p]);
        crCount[p] += int'(creditReturns[p]);
        assert (avail <= QUEUE_DEPTH)
        else noteFailure($sformatf("port %0d got more credits back than it spent.", p));
        if (avail > 0 && pend[p].size() > 0)
        begin
          if (pend[p][0].kind == FLIT_HEAD)
            pendPkts[p]--;
          if (p == 0 && firstDrive < 0)
            firstDrive = cycle;
          inFlits[p]  <= pend[p].pop_front();
          inValids[p] <= 1'b1;
          avail--;
          sent[p]++;
          nDriven++;
        end
        else
          inValids[p] <= 1'b0;
        cred[p] = avail;
        if (rotOn && pendPkts[p] < 2)
          queuePacket(p, randomLen());  // keeps every source backlogged.
      end
    end
    drivenTotal <= drivenTotal + nDriven;
  end

  always @(posedge clk)
  begin
    flit_t f;
    int    src;
    int    pkt;
    int    field;
    if (rst)
      outCredit <= 1'b0;
    else
    begin
      if (outValid)
      begin
        f     = outFlit;
        src   = int'(f.payload[15:13]);
        pkt   = int'(f.payload[12:8]);
        field = int'(f.payload[7:0]);
        received++;
        owed++;
        if (firstOut < 0)
          firstOut = cycle;
        if (f.kind == FLIT_HEAD)
          checkHead(src, pkt, field);
        else
          checkBody(f.kind, src, pkt, field);
      end
      // the downstream buffer frees slots at random and sometimes holds them back.
      if (stallLeft > 0)
        stallLeft--;
      else if (stallsOn && $urandom_range(0, 24) == 0)
      begin
        stallLeft = int'($urandom_range(10, 30));
        stalls++;
      end
      if (stallLeft == 0 && owed > 0 && $urandom_range(0, 1) == 1)
      begin
        outCredit <= 1'b1;
        owed--;
        returned++;
      end
      else
        outCredit <= 1'b0;
      if (!outValid && (received - returned) < DOWNSTREAM_DEPTH && drivenTotal > received)
        idleRun++;
      else
        idleRun = 0;
      assert (idleRun < 12)
      else
      begin
        noteFailure("output stayed idle although flits and credits were available.");
        idleRun = 0;
      end
    end
    cycle <= cycle + 1;
  end

  always @(posedge clk)
  begin
    rstQ  <= rst;
    rstQ2 <= rstQ;
  end

  assert property (@(posedge clk) (rstQ || rstQ2) |-> (!outValid && creditReturns == '0))
    else reportMismatch("outValid or a creditReturn is high around reset.");

  assert property (@(posedge clk) disable iff (rst) (received - returned) <= DOWNSTREAM_DEPTH)
    else reportMismatch($sformatf("%0d flits outstanding downstream", received - returned));

  // the run may take at most 40 cycles per flit plus some slack.
  always @(posedge clk)
  begin
    if (cycle > 200 + 40 * totalFlits)
    begin
      $display("Timeout: only %0d of %0d flits arrived in time.", received, totalFlits);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h9ca6_d14e));
    rst       = 1'b1;
    inValids  = '0;
    outCredit = 1'b0;
    remaining = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inFlits[p]  = '0;
      cred[p]     = QUEUE_DEPTH;
      pendPkts[p] = 0;
      pktNum[p]   = 0;
      expPkt[p]   = 0;
      sent[p]     = 0;
      crCount[p]  = 0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // a lone head on Local through an empty port.
    @(negedge clk);
    queuePacket(0, 1);
    waitDrain();
    assert (firstOut - firstDrive - 1 == 3)
    else reportMismatch($sformatf("idle latency %0d cycles, expected 3",
                                  firstOut - firstDrive - 1));

    // every port backlogged, so heads must rotate L, N, E, W, S.
    prevHead = -1;
    rotHeads = 0;
    rotOn    = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
      repeat (3) queuePacket(p, randomLen());
    while (rotHeads < 30)
      @(negedge clk);
    rotOn = 1'b0;
    waitDrain();

    // random traffic with downstream stalls.
    stallsOn = 1'b1;
    for (int n = 0; n < 40; n++)
      queuePacket(int'($urandom_range(0, NUM_PORTS - 1)), randomLen());
    waitDrain();
    stallsOn = 1'b0;
    repeat (3) @(negedge clk);

    for (int p = 0; p < NUM_PORTS; p++)
      assert (crCount[p] == sent[p])
      else reportMismatch($sformatf("port %0d got %0d credits back for %0d flits",
                                    p, crCount[p], sent[p]));
    assert (stalls > 0)
    else noteFailure("the downstream model never withheld credits.");

    $display("Run complete: %0d flits, %0d stalls, %0d errors.", received, stalls, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/nocPkg.sv
design/arbPkg.sv
design/inputQueue.sv
design/packetTracker.sv
design/outputArbiter.sv
design/outputLink.sv
design/routerOutputPort.sv
tests/tbRouterOutputPort.sv

// ==== Makefile ====
TOP := tbRouterOutputPort

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

# the run fails on a non-zero exit or when the log holds the fail message.
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Testbench failed" sim.log

clean:
	rm -rf obj_dir sim.log
